// File: tb.f
mips_pkg.sv
alu.sv
regfile.sv
control.sv
hazard_unit.sv
cpu.sv
tb_clock.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: mips_pipe

sources:
  - mips_pkg.sv
  - alu.sv
  - regfile.sv
  - control.sv
  - hazard_unit.sv
  - cpu.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr, imem_rdata;
	logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
	logic        dmem_we, dmem_re;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] end_addr;
	integer      seed;
	int          n_words = 0;
	int          store_idx = 0;
	int          errors = 0;

	tb_clock #(.RESET_CYCLES(8)) i_clock (.clk(clk), .rst_n(rst_n));

	cpu #(.RESET_PC(RESET_PC)) i_dut (
		.clk(clk), .rst_n(rst_n),
		.imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata)
	);

	////////////////////
	// Helpers
	////////////////////

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Initial data memory contents
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		fill_word = (addr * 32'h9e37_79b9) ^ 32'h3c5a_0f17;
	endfunction

	function automatic logic [15:0] rnd16();
		logic [31:0] v;
		v = $random(seed);
		rnd16 = v[15:0];
	endfunction

	function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		rtype_word = {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		itype_word = {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [31:0] target);
		jump_word = {op, target[27:2]};
	endfunction

	task automatic put(input logic [31:0] word);
		imem[n_words] = word;
		n_words++;
	endtask

	////////////////////
	// Reference ISA model
	////////////////////

	// Runs the program without a pipeline and records every store in order
	function automatic void run_model();
		logic [31:0] r [32];
		logic [31:0] m [256];
		logic [31:0] pc, pc4, next, ins, a, b, sext, zext, addr;
		logic [5:0]  op, fn;
		logic [4:0]  rs, rt, rd, sh;
		logic        done;
		int          steps;
		int          i;
		for (i = 0; i < 32; i++)
			r[i] = 32'd0;
		for (i = 0; i < 256; i++)
			m[i] = fill_word(i * 4);
		pc = RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			ins = imem[pc[9:2]];
			op = ins[31:26];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			sh = ins[10:6];
			fn = ins[5:0];
			a = r[rs];
			b = r[rt];
			sext = {{16{ins[15]}}, ins[15:0]};
			zext = {16'h0000, ins[15:0]};
			addr = a + sext;
			pc4 = pc + 32'd4;
			next = pc4;
			case (op)
				mips_pkg::OP_RTYPE: begin
					case (fn)
						mips_pkg::FN_ADD: r[rd] = a + b;
						mips_pkg::FN_SUB: r[rd] = a - b;
						mips_pkg::FN_AND: r[rd] = a & b;
						mips_pkg::FN_OR:  r[rd] = a | b;
						mips_pkg::FN_SLT: r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						mips_pkg::FN_SLL: r[rd] = b << sh;
						mips_pkg::FN_JR:  next = a;
						default: ;
					endcase
				end
				mips_pkg::OP_ADDI: r[rt] = a + sext;
				mips_pkg::OP_ANDI: r[rt] = a & zext;
				mips_pkg::OP_ORI:  r[rt] = a | zext;
				mips_pkg::OP_LW:   r[rt] = m[addr[9:2]];
				mips_pkg::OP_SW: begin
					m[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				mips_pkg::OP_BEQ: if (a == b) next = pc4 + {sext[29:0], 2'b00};
				mips_pkg::OP_BNE: if (a != b) next = pc4 + {sext[29:0], 2'b00};
				mips_pkg::OP_J: begin
					next = {pc4[31:28], ins[25:0], 2'b00};
					// A self-jump ends the program
					done = (next == pc);
				end
				mips_pkg::OP_JAL: begin
					r[31] = pc4;
					next = {pc4[31:28], ins[25:0], 2'b00};
				end
				default: ;
			endcase
			r[0] = 32'd0;
			pc = next;
			steps++;
		end
	endfunction

	////////////////////
	// Memory models and store monitor
	////////////////////

	always @(negedge clk) begin
		if (dmem_we)
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		imem_rdata <= imem[imem_addr[9:2]];
		dmem_rdata <= dmem_re ? dmem[dmem_addr[9:2]] : 32'd0;
	end

	always @(negedge clk) begin
		if (rst_n && dmem_we) begin
			if (store_idx < exp_addr.size()) begin
				check("dmem_addr", dmem_addr, exp_addr[store_idx]);
				check("dmem_wdata", dmem_wdata, exp_data[store_idx]);
			end else begin
				errors++;
				$display("%0t: unexpected store to %h after all %0d expected stores",
					$time, dmem_addr, exp_addr.size());
			end
			store_idx++;
		end
	end

	// Watchdog sized from the program length
	initial begin
		@(posedge rst_n);
		repeat (4 * n_words + 200) @(posedge clk);
		$display("Timeout: the program never settled in its final self-jump");
		$display("Stores checked: %0d, errors: %0d", store_idx, errors + 1);
		$display("Checks failed");
		$finish;
	end

	////////////////////
	// Program and test sequence
	////////////////////

	initial begin
		logic [15:0] v;
		logic [31:0] f_addr;
		int          jal_idx;
		int          end_fetches;
		int          first_store_idx;
		int          mem_cycle;
		imem_rdata = 32'd0;
		dmem_rdata = 32'd0;
		seed = 32'h4710_e412;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'd0;
			dmem[i] = fill_word(i * 4);
		end

		// Result area base in r1
		put(itype_word(mips_pkg::OP_ADDI, 1, 0, 16'h0100));
		// Dependent chain, forwarding from EX, MEM and WB
		put(itype_word(mips_pkg::OP_ADDI, 2, 0, rnd16()));
		put(itype_word(mips_pkg::OP_ADDI, 3, 2, rnd16()));
		put(itype_word(mips_pkg::OP_ORI, 4, 3, rnd16()));
		put(rtype_word(mips_pkg::FN_ADD, 5, 2, 4, 0));
		put(rtype_word(mips_pkg::FN_SUB, 6, 5, 3, 0));
		put(itype_word(mips_pkg::OP_ANDI, 7, 6, rnd16()));
		first_store_idx = n_words;
		put(itype_word(mips_pkg::OP_SW, 7, 1, 16'd0));
		put(itype_word(mips_pkg::OP_SW, 5, 1, 16'd4));
		put(itype_word(mips_pkg::OP_SW, 6, 1, 16'd8));
		// Load-use pairs
		put(itype_word(mips_pkg::OP_LW, 8, 0, 16'h0040));
		put(rtype_word(mips_pkg::FN_ADD, 9, 8, 2, 0));
		put(itype_word(mips_pkg::OP_SW, 9, 1, 16'd12));
		put(itype_word(mips_pkg::OP_LW, 10, 0, 16'h0044));
		put(itype_word(mips_pkg::OP_SW, 10, 1, 16'd16));
		put(itype_word(mips_pkg::OP_LW, 11, 1, 16'd0));
		put(itype_word(mips_pkg::OP_SW, 11, 1, 16'd20));
		// Branches, the two slots after a taken one must not store
		put(itype_word(mips_pkg::OP_BEQ, 2, 2, 16'd2));
		put(itype_word(mips_pkg::OP_SW, 2, 1, 16'd24));
		put(itype_word(mips_pkg::OP_SW, 3, 1, 16'd28));
		put(itype_word(mips_pkg::OP_BEQ, 1, 0, 16'd1));
		put(itype_word(mips_pkg::OP_SW, 4, 1, 16'd32));
		put(itype_word(mips_pkg::OP_BNE, 1, 0, 16'd2));
		put(itype_word(mips_pkg::OP_SW, 5, 1, 16'd36));
		put(itype_word(mips_pkg::OP_SW, 6, 1, 16'd40));
		put(itype_word(mips_pkg::OP_BNE, 3, 3, 16'd1));
		put(itype_word(mips_pkg::OP_SW, 7, 1, 16'd44));
		// Call, target patched once the subroutine is placed
		jal_idx = n_words;
		put(32'd0);
		put(itype_word(mips_pkg::OP_SW, 31, 1, 16'd48));
		// slt and sll on random operands, writes to r0
		put(itype_word(mips_pkg::OP_ADDI, 14, 0, rnd16()));
		put(itype_word(mips_pkg::OP_ADDI, 15, 0, rnd16()));
		put(rtype_word(mips_pkg::FN_SLT, 16, 14, 15, 0));
		put(rtype_word(mips_pkg::FN_SLT, 17, 15, 14, 0));
		v = rnd16();
		put(rtype_word(mips_pkg::FN_SLL, 18, 0, 14, v[4:0]));
		put(itype_word(mips_pkg::OP_ORI, 19, 0, rnd16()));
		put(rtype_word(mips_pkg::FN_SLL, 20, 0, 19, 5'd16));
		put(rtype_word(mips_pkg::FN_SLT, 21, 20, 14, 0));
		put(itype_word(mips_pkg::OP_ADDI, 0, 0, rnd16()));
		put(rtype_word(mips_pkg::FN_ADD, 0, 14, 15, 0));
		put(itype_word(mips_pkg::OP_SW, 16, 1, 16'd52));
		put(itype_word(mips_pkg::OP_SW, 17, 1, 16'd56));
		put(itype_word(mips_pkg::OP_SW, 18, 1, 16'd60));
		put(itype_word(mips_pkg::OP_SW, 21, 1, 16'd64));
		put(itype_word(mips_pkg::OP_SW, 0, 1, 16'd68));
		// Final self-jump
		end_addr = n_words * 4;
		put(jump_word(mips_pkg::OP_J, end_addr));
		// Subroutine
		f_addr = n_words * 4;
		imem[jal_idx] = jump_word(mips_pkg::OP_JAL, f_addr);
		put(itype_word(mips_pkg::OP_ADDI, 12, 0, rnd16()));
		put(itype_word(mips_pkg::OP_SW, 12, 1, 16'd72));
		put(rtype_word(mips_pkg::FN_JR, 0, 31, 0, 0));

		run_model();

		// State right after reset and before anything reaches MEM
		@(posedge rst_n);
		check("imem_addr", imem_addr, RESET_PC);
		check("dmem_we", dmem_we, 1'b0);
		check("dmem_re", dmem_re, 1'b0);
		mem_cycle = 0;
		while (!dmem_we && !dmem_re) begin
			@(negedge clk);
			mem_cycle++;
		end
		// First memory access is the first store, three cycles after its fetch
		check("dmem_re", dmem_re, 1'b0);
		check("first dmem_we cycle", mem_cycle, first_store_idx + 3);

		// Second fetch of the self-jump means everything before it has drained
		end_fetches = 0;
		while (end_fetches < 2) begin
			@(negedge clk);
			if (imem_addr == end_addr)
				end_fetches++;
		end
		repeat (4) @(negedge clk);

		if (store_idx < exp_addr.size()) begin
			errors++;
			$display("Missing stores: only %0d of %0d expected stores were seen",
				store_idx, exp_addr.size());
		end
		$display("Stores checked: %0d, errors: %0d", store_idx, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Release on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: cpu.sv
`timescale 1ns/10ps

module cpu #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst_n,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	output logic        dmem_re,
	input  logic [31:0] dmem_rdata
);

	// Fetch
	logic [31:0] pc, pc_plus4, pc_next;
	// Decode
	logic [31:0] id_pc4;
	mips_pkg::instr_u id_instr;
	logic id_reg_write, id_reg_dst, id_alu_src, id_mem_read, id_mem_write;
	logic id_branch, id_branch_ne, id_jump, id_jump_reg, id_link;
	mips_pkg::alu_op_e id_alu_op;
	logic [31:0] rf_rs_data, rf_rt_data, id_rs_data, id_rt_data;
	logic [31:0] id_imm, id_jtarget;
	logic id_zext;
	logic [1:0] fwd_rs, fwd_rt;
	logic stall;
	// Execute
	logic ex_reg_write, ex_reg_dst, ex_alu_src, ex_mem_read, ex_mem_write;
	logic ex_branch, ex_branch_ne, ex_jump, ex_jump_reg, ex_link;
	mips_pkg::alu_op_e ex_alu_op;
	logic [31:0] ex_pc4, ex_rs_data, ex_rt_data, ex_imm, ex_jtarget;
	logic [4:0] ex_rt, ex_rd, ex_shamt, ex_dst;
	logic [31:0] alu_b, alu_result, ex_result, ex_branch_target;
	logic alu_zero, branch_taken, redirect;
	// Memory and write back
	logic mem_reg_write, mem_mem_read, mem_mem_write;
	logic [31:0] mem_result, mem_rt_data, mem_wdata;
	logic [4:0] mem_dst;
	logic wb_reg_write;
	logic [31:0] wb_wdata;
	logic [4:0] wb_dst;

	// Select 0 is the register file, then EX, MEM, WB
	function automatic logic [31:0] fwd_mux(input logic [1:0] sel, input logic [31:0] rf,
			input logic [31:0] ex, input logic [31:0] mem, input logic [31:0] wb);
		case (sel)
			2'd1:    fwd_mux = ex;
			2'd2:    fwd_mux = mem;
			2'd3:    fwd_mux = wb;
			default: fwd_mux = rf;
		endcase
	endfunction

	////////////////////
	// Fetch
	////////////////////

	assign imem_addr = pc;
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		if (branch_taken)
			pc_next = ex_branch_target;
		else if (ex_jump)
			pc_next = ex_jtarget;
		else if (ex_jump_reg)
			pc_next = ex_rs_data;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	// IF/ID, a zero word is the bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_instr <= '0;
		else if (redirect)
			id_instr <= '0;
		else if (!stall)
			id_instr <= imem_rdata;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			id_pc4 <= pc_plus4;
	end

	////////////////////
	// Decode
	////////////////////

	control i_control (
		.instr(id_instr), .reg_write(id_reg_write), .reg_dst(id_reg_dst),
		.alu_src(id_alu_src), .mem_read(id_mem_read), .mem_write(id_mem_write),
		.branch(id_branch), .branch_ne(id_branch_ne), .jump(id_jump),
		.jump_reg(id_jump_reg), .link(id_link), .alu_op(id_alu_op)
	);

	regfile i_regfile (
		.clk(clk), .rst_n(rst_n),
		.rs_addr(id_instr.r.rs), .rt_addr(id_instr.r.rt),
		.rs_data(rf_rs_data), .rt_data(rf_rt_data),
		.we(wb_reg_write), .wr_addr(wb_dst), .wr_data(wb_wdata)
	);

	hazard_unit i_hazard_unit (
		.instr(id_instr),
		.ex_dst(ex_dst), .ex_write(ex_reg_write), .ex_load(ex_mem_read),
		.mem_dst(mem_dst), .mem_write(mem_reg_write),
		.wb_dst(wb_dst), .wb_write(wb_reg_write),
		.fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .stall(stall)
	);

	assign id_rs_data = fwd_mux(fwd_rs, rf_rs_data, ex_result, mem_wdata, wb_wdata);
	assign id_rt_data = fwd_mux(fwd_rt, rf_rt_data, ex_result, mem_wdata, wb_wdata);

	// Logical immediates are zero extended
	assign id_zext = (id_instr.i.opcode == mips_pkg::OP_ANDI) ||
		(id_instr.i.opcode == mips_pkg::OP_ORI);
	assign id_imm = id_zext ? {16'h0000, id_instr.i.imm} :
		{{16{id_instr.i.imm[15]}}, id_instr.i.imm};
	assign id_jtarget = {id_pc4[31:28], id_instr.r[25:0], 2'b00};

	// ID/EX control, cleared on flush and on a load-use stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{ex_reg_write, ex_reg_dst, ex_alu_src, ex_mem_read, ex_mem_write} <= '0;
			{ex_branch, ex_branch_ne, ex_jump, ex_jump_reg, ex_link} <= '0;
			ex_alu_op <= mips_pkg::ALU_ADD;
		end else if (redirect || stall) begin
			{ex_reg_write, ex_reg_dst, ex_alu_src, ex_mem_read, ex_mem_write} <= '0;
			{ex_branch, ex_branch_ne, ex_jump, ex_jump_reg, ex_link} <= '0;
			ex_alu_op <= mips_pkg::ALU_ADD;
		end else begin
			{ex_reg_write, ex_reg_dst, ex_alu_src, ex_mem_read, ex_mem_write} <=
				{id_reg_write, id_reg_dst, id_alu_src, id_mem_read, id_mem_write};
			{ex_branch, ex_branch_ne, ex_jump, ex_jump_reg, ex_link} <=
				{id_branch, id_branch_ne, id_jump, id_jump_reg, id_link};
			ex_alu_op <= id_alu_op;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc4     <= id_pc4;
		ex_rs_data <= id_rs_data;
		ex_rt_data <= id_rt_data;
		ex_imm     <= id_imm;
		ex_jtarget <= id_jtarget;
		ex_rt      <= id_instr.r.rt;
		ex_rd      <= id_instr.r.rd;
		ex_shamt   <= id_instr.r.shamt;
	end

	////////////////////
	// Execute
	////////////////////

	assign alu_b = ex_alu_src ? ex_imm : ex_rt_data;

	alu i_alu (
		.op(ex_alu_op), .a(ex_rs_data), .b(alu_b), .shamt(ex_shamt),
		.result(alu_result), .zero(alu_zero)
	);

	assign ex_result = ex_link ? ex_pc4 : alu_result;
	assign ex_dst = ex_link ? 5'd31 : (ex_reg_dst ? ex_rd : ex_rt);
	assign ex_branch_target = ex_pc4 + {ex_imm[29:0], 2'b00};
	// bne inverts the sense of the zero flag
	assign branch_taken = ex_branch && (alu_zero ^ ex_branch_ne);
	assign redirect = branch_taken || ex_jump || ex_jump_reg;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			{mem_reg_write, mem_mem_read, mem_mem_write} <= '0;
		else
			{mem_reg_write, mem_mem_read, mem_mem_write} <=
				{ex_reg_write, ex_mem_read, ex_mem_write};
	end

	always_ff @(posedge clk) begin
		mem_result  <= ex_result;
		mem_rt_data <= ex_rt_data;
		mem_dst     <= ex_dst;
	end

	////////////////////
	// Memory and write back
	////////////////////

	assign dmem_addr  = mem_result;
	assign dmem_wdata = mem_rt_data;
	assign dmem_we    = mem_mem_write;
	assign dmem_re    = mem_mem_read;
	assign mem_wdata  = mem_mem_read ? dmem_rdata : mem_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_reg_write <= 1'b0;
		else
			wb_reg_write <= mem_reg_write;
	end

	always_ff @(posedge clk) begin
		wb_wdata <= mem_wdata;
		wb_dst   <= mem_dst;
	end

endmodule

// File: hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
	input  mips_pkg::instr_u instr,
	input  logic [4:0]       ex_dst,
	input  logic             ex_write,
	input  logic             ex_load,
	input  logic [4:0]       mem_dst,
	input  logic             mem_write,
	input  logic [4:0]       wb_dst,
	input  logic             wb_write,
	output logic [1:0]       fwd_rs,
	output logic [1:0]       fwd_rt,
	output logic             stall
);

	logic [4:0] rs, rt;
	logic reads_rs, reads_rt;

	// Youngest writer wins, a load in EX has no data yet
	function automatic logic [1:0] pick(input logic [4:0] src);
		if (src == 5'd0)
			pick = 2'd0;
		else if (ex_write && !ex_load && ex_dst == src)
			pick = 2'd1;
		else if (mem_write && mem_dst == src)
			pick = 2'd2;
		else if (wb_write && wb_dst == src)
			pick = 2'd3;
		else
			pick = 2'd0;
	endfunction

	assign rs = instr.r.rs;
	assign rt = instr.r.rt;

	// Jumps carry a target in the rs field
	assign reads_rs = !(instr.i.opcode == mips_pkg::OP_J || instr.i.opcode == mips_pkg::OP_JAL);
	assign reads_rt = (instr.i.opcode == mips_pkg::OP_RTYPE) ||
		(instr.i.opcode == mips_pkg::OP_SW) ||
		(instr.i.opcode == mips_pkg::OP_BEQ) ||
		(instr.i.opcode == mips_pkg::OP_BNE);

	always_comb begin
		fwd_rs = pick(rs);
		fwd_rt = pick(rt);
	end

	// Load-use costs one bubble
	assign stall = ex_load && (ex_dst != 5'd0) &&
		((reads_rs && ex_dst == rs) || (reads_rt && ex_dst == rt));

endmodule

// File: control.sv
`timescale 1ns/10ps

module control (
	input  mips_pkg::instr_u  instr,
	output logic              reg_write,
	output logic              reg_dst,
	output logic              alu_src,
	output logic              mem_read,
	output logic              mem_write,
	output logic              branch,
	output logic              branch_ne,
	output logic              jump,
	output logic              jump_reg,
	output logic              link,
	output mips_pkg::alu_op_e alu_op
);

	always_comb begin
		// Anything not listed falls through as a bubble
		{reg_write, reg_dst, alu_src, mem_read, mem_write} = '0;
		{branch, branch_ne, jump, jump_reg, link} = '0;
		alu_op = mips_pkg::ALU_ADD;

		case (instr.i.opcode)
			mips_pkg::OP_RTYPE: begin
				case (instr.r.funct)
					mips_pkg::FN_ADD: {reg_write, reg_dst} = 2'b11;
					mips_pkg::FN_SUB: begin
						{reg_write, reg_dst} = 2'b11;
						alu_op = mips_pkg::ALU_SUB;
					end
					mips_pkg::FN_AND: begin
						{reg_write, reg_dst} = 2'b11;
						alu_op = mips_pkg::ALU_AND;
					end
					mips_pkg::FN_OR: begin
						{reg_write, reg_dst} = 2'b11;
						alu_op = mips_pkg::ALU_OR;
					end
					mips_pkg::FN_SLT: begin
						{reg_write, reg_dst} = 2'b11;
						alu_op = mips_pkg::ALU_SLT;
					end
					mips_pkg::FN_SLL: begin
						{reg_write, reg_dst} = 2'b11;
						alu_op = mips_pkg::ALU_SLL;
					end
					mips_pkg::FN_JR: jump_reg = 1'b1;
					default: ;
				endcase
			end
			mips_pkg::OP_ADDI: {reg_write, alu_src} = 2'b11;
			mips_pkg::OP_ANDI: begin
				{reg_write, alu_src} = 2'b11;
				alu_op = mips_pkg::ALU_AND;
			end
			mips_pkg::OP_ORI: begin
				{reg_write, alu_src} = 2'b11;
				alu_op = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_LW: {reg_write, alu_src, mem_read} = 3'b111;
			mips_pkg::OP_SW: {alu_src, mem_write} = 2'b11;
			// Branch compare runs through the ALU subtract
			mips_pkg::OP_BEQ: begin
				branch = 1'b1;
				alu_op = mips_pkg::ALU_SUB;
			end
			mips_pkg::OP_BNE: begin
				{branch, branch_ne} = 2'b11;
				alu_op = mips_pkg::ALU_SUB;
			end
			mips_pkg::OP_J: jump = 1'b1;
			mips_pkg::OP_JAL: {jump, link, reg_write} = 3'b111;
			default: ;
		endcase
	end

endmodule

// File: regfile.sv
`timescale 1ns/10ps

module regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	input  logic        we,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (we && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Register 0 reads as zero
	assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

// File: alu.sv
`timescale 1ns/10ps

module alu (
	input  mips_pkg::alu_op_e op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [4:0]        shamt,
	output logic [31:0]       result,
	output logic              zero
);

	logic [31:0] diff;

	// Shared by sub and slt
	assign diff = a - b;

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: result = a + b;
			mips_pkg::ALU_SUB: result = diff;
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR:  result = a | b;
			// Signed compare, overflow of the subtract taken into account
			mips_pkg::ALU_SLT: result = {31'd0, (a[31] != b[31]) ? a[31] : diff[31]};
			mips_pkg::ALU_SLL: result = b << shamt;
			default:           result = a + b;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

// File: mips_pkg.sv
package mips_pkg;

	////////////////////
	// Primary opcodes
	////////////////////

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	////////////////////
	// R-type function codes
	////////////////////

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_JR  = 6'h08;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// ALU operations
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SLT = 4'd4,
		ALU_SLL = 4'd5
	} alu_op_e;

	////////////////////
	// Instruction word views
	////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} instr_i_t;

	// Same 32 bits, read as R fields or I fields
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage
